// ==== list.f ====
common/zap_pkg.sv
verilog/zap_cfg_regs.sv
verilog/zap_wb_merger.sv
wb_adapter/zap_store_buffer.sv
wb_adapter/zap_wb_adapter.sv
verilog/zap_top.sv
verif/zap_assertions.sv
verif/zap_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module zap_tb -o zap_sim
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

out=$(./obj_dir/zap_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
        exit 0
fi
exit 1

// ==== verif/zap_tb.sv ====
// Testbench with clock, operation table, external memory model and compare tasks.
module zap_tb;
timeunit 1ns;
timeprecision 1ps;

localparam int NUM_OPS = 23;
localparam int P_CODE = 0, P_DATA = 1, P_APB = 2, P_BOTH = 3, P_LVL = 4;

typedef struct {
        int                             port;   // Which port drives it.
        bit                             we;
        logic [zap_pkg::ZAP_AW-1:0]     adr;
        logic [zap_pkg::ZAP_SELW-1:0]   sel;
        logic [zap_pkg::ZAP_DW-1:0]     dat;
        logic [zap_pkg::ZAP_DW-1:0]     exp;    // APB reads only.
        bit                             err;    // Expected pslverr.
} op_t;

logic i_clk, i_arst_n, i_ic_stb, i_dc_stb, i_dc_we, i_psel, i_penable, i_pwrite;
logic                           i_wb_ack = 1'b0;            // Driven by the memory model.
logic [zap_pkg::ZAP_AW-1:0]     i_ic_adr, i_dc_adr, o_wb_adr;
logic [zap_pkg::ZAP_DW-1:0]     i_dc_dat, i_pwdata, o_ic_dat, o_dc_dat, o_prdata;
logic [zap_pkg::ZAP_DW-1:0]     i_wb_dat = '0;              // Driven by the memory model.
logic [zap_pkg::ZAP_DW-1:0]     o_wb_dat;
logic [zap_pkg::ZAP_SELW-1:0]   i_dc_sel, o_wb_sel;
logic [zap_pkg::ZAP_APB_AW-1:0] i_paddr;
logic o_ic_ack, o_dc_ack, o_pready, o_pslverr, o_wb_cyc, o_wb_stb, o_wb_we;

op_t                            ops [NUM_OPS];
logic [31:0]                    ref_mem [logic [31:0]];     // Expected contents.
logic [31:0]                    ext_mem [logic [31:0]];     // Model contents.
logic [31:0]                    exp_adr [$], exp_dat [$];   // Expected bus order.
bit                             exp_we [$];
logic [31:0]                    rng = 32'd96776;
logic [6:0]                     tb_pid = '0;
int                             fails = 0, wcnt = 0;
bit                             busy = 0;

zap_top dut0 (.*);

initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
end

function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
endfunction

// Unwritten words. Word address folded in fully.
function automatic logic [31:0] fill(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ {a[17:2], a[31:16]} ^ 32'h5AC3_3CA5;
endfunction

// Below 32 MB the PID selects a 32 MB slot.
function automatic logic [31:0] reloc(input logic [31:0] a);
        if (a < 32'h0200_0000)
                return a + {tb_pid, 25'd0};
        return a;
endfunction

function automatic logic [31:0] ref_read(input logic [31:0] a);
        return ref_mem.exists(a >> 2) ? ref_mem[a >> 2] : fill(a);
endfunction

function automatic logic [31:0] merge(input logic [31:0] old, nw, input logic [3:0] sel);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++)
                if (sel[b]) r[8*b +: 8] = nw[8*b +: 8];
        return r;
endfunction

task automatic stop_run(input string why);
        fails++;
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
endtask

task automatic check_word(input string name, input logic [zap_pkg::ZAP_DW-1:0] got, exp);
        if (got !== exp)
                stop_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
endtask

task automatic check_adr(input string name, input logic [zap_pkg::ZAP_AW-1:0] got, exp);
        if (got !== exp)
                stop_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp)
                stop_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

// ------------------------------------------------------------
// External memory model with random wait states.
// ------------------------------------------------------------

always @(negedge i_clk) begin
        if (i_wb_ack) begin
                i_wb_ack = 1'b0;                // Slave done. Stb drops.
                busy = 0;
        end else if (o_wb_stb) begin
                if (!busy) begin
                        busy = 1;
                        wcnt = xorshift() % 4;
                end
                if (wcnt != 0) begin
                        wcnt--;
                end else begin
                        if (exp_adr.size() != 0) begin   // Ordered traffic.
                                check_adr("o_wb_adr", o_wb_adr, exp_adr.pop_front());
                                check_bit("o_wb_we", o_wb_we, exp_we.pop_front());
                                if (o_wb_we)
                                        check_word("o_wb_dat", o_wb_dat, exp_dat.pop_front());
                                else
                                        void'(exp_dat.pop_front());
                        end
                        if (o_wb_we) begin
                                ext_mem[o_wb_adr >> 2] = merge(
                                        ext_mem.exists(o_wb_adr >> 2) ?
                                        ext_mem[o_wb_adr >> 2] : fill(o_wb_adr),
                                        o_wb_dat, o_wb_sel);
                        end else begin
                                i_wb_dat = ext_mem.exists(o_wb_adr >> 2) ?
                                        ext_mem[o_wb_adr >> 2] : fill(o_wb_adr);
                        end
                        i_wb_ack = 1'b1;
                end
        end
end

task automatic apb_access(input op_t op, output logic [31:0] rd, output logic err);
        @(negedge i_clk);
        i_psel = 1'b1;
        i_penable = 1'b0;
        i_pwrite = op.we;
        i_paddr = op.adr[3:0];
        i_pwdata = op.dat;
        @(negedge i_clk);
        i_penable = 1'b1;                       // Access phase.
        #1;
        rd = o_prdata;
        err = o_pslverr;
        check_bit("o_pready", o_pready, 1'b1);  // No wait states.
        @(negedge i_clk);
        i_psel = 1'b0;
        i_penable = 1'b0;
endtask

// One request on a CPU port, held until ack.
task automatic port_access(input op_t op, output logic [31:0] rd);
        @(negedge i_clk);
        if (op.port == P_CODE) begin
                i_ic_stb = 1'b1;
                i_ic_adr = op.adr;
        end else begin
                i_dc_stb = 1'b1;
                i_dc_we = op.we;
                i_dc_sel = op.sel;
                i_dc_adr = op.adr;
                i_dc_dat = op.dat;
        end
        do @(negedge i_clk); while (!(op.port == P_CODE ? o_ic_ack : o_dc_ack));
        rd = (op.port == P_CODE) ? o_ic_dat : o_dc_dat;
        i_ic_stb = 1'b0;
        i_dc_stb = 1'b0;
endtask

// Both ports held busy. Three reads each.
task automatic both_ports();
        int ic_left, dc_left, ic_other, dc_other;
        ic_left = 3;
        dc_left = 3;
        ic_other = 0;
        dc_other = 0;
        @(negedge i_clk);
        i_ic_stb = 1'b1;
        i_ic_adr = 32'h0000_3002;
        i_dc_stb = 1'b1;
        i_dc_we = 1'b0;
        i_dc_sel = 4'hF;
        i_dc_adr = 32'h0000_3100;
        while (ic_left > 0 || dc_left > 0) begin
                @(negedge i_clk);
                if (o_ic_ack) begin
                        check_word("o_ic_dat", o_ic_dat, ref_read(reloc(i_ic_adr & ~32'h3)));
                        ic_left--;
                        ic_other = 0;
                        if (dc_left > 0) dc_other++;
                        i_ic_adr = i_ic_adr + 32'h4;
                        i_ic_stb = (ic_left > 0);
                end
                if (o_dc_ack) begin
                        check_word("o_dc_dat", o_dc_dat, ref_read(reloc(i_dc_adr)));
                        dc_left--;
                        dc_other = 0;
                        if (ic_left > 0) ic_other++;
                        i_dc_adr = i_dc_adr + 32'h4;
                        i_dc_stb = (dc_left > 0);
                end
                if (ic_other > 2 || dc_other > 2)
                        stop_run("A port waited for more than two grants of the other port.");
        end
endtask

initial begin
        #(NUM_OPS * 40 * 40 + 8 * 40);
        $display("Timeout, the DUT stopped answering.");
        $display("Simulation FAILED");
        $fatal(1);
end

initial begin
        logic [31:0] rd, ea, ed;
        logic        err;
        i_arst_n = 1'b0;
        {i_ic_stb, i_dc_stb, i_dc_we, i_psel, i_penable, i_pwrite} = '0;
        {i_ic_adr, i_dc_adr, i_dc_dat, i_pwdata} = '0;
        i_dc_sel = '0;
        i_paddr = '0;
        //       port    we  adr             sel   dat             exp    err
        ops[0]  = '{P_APB,  1, 32'h0,         4'h0, 32'h0000_0005, 32'h0, 0};
        ops[1]  = '{P_APB,  0, 32'h0,         4'h0, 32'h0,         32'h5, 0};
        ops[2]  = '{P_APB,  1, 32'h8,         4'h0, 32'h0000_007F, 32'h0, 1};
        ops[3]  = '{P_APB,  1, 32'h4,         4'h0, 32'h0000_0001, 32'h0, 1};
        ops[4]  = '{P_APB,  0, 32'hC,         4'h0, 32'h0,         32'h0, 1};
        ops[5]  = '{P_APB,  0, 32'h0,         4'h0, 32'h0,         32'h5, 0};
        ops[6]  = '{P_DATA, 1, 32'h0000_1000, 4'hF, 32'h1122_3344, 32'h0, 0};
        ops[7]  = '{P_DATA, 1, 32'h0000_1000, 4'h5, 32'hAABB_CCDD, 32'h0, 0};
        ops[8]  = '{P_DATA, 0, 32'h0000_1000, 4'hF, 32'h0,         32'h0, 0};
        ops[9]  = '{P_DATA, 0, 32'h0400_0000, 4'hF, 32'h0,         32'h0, 0};
        ops[10] = '{P_CODE, 0, 32'h0000_1006, 4'hF, 32'h0,         32'h0, 0};
        ops[11] = '{P_DATA, 1, 32'h0000_2000, 4'hF, 32'h0000_0001, 32'h0, 0};
        ops[12] = '{P_DATA, 1, 32'h0000_2004, 4'hF, 32'h0000_0002, 32'h0, 0};
        ops[13] = '{P_DATA, 1, 32'h0000_2000, 4'hF, 32'h0000_0003, 32'h0, 0};
        ops[14] = '{P_DATA, 1, 32'h0000_2008, 4'h3, 32'h0000_0004, 32'h0, 0};
        ops[15] = '{P_DATA, 1, 32'h0000_2000, 4'hF, 32'h0000_0005, 32'h0, 0};
        ops[16] = '{P_DATA, 1, 32'h0000_200C, 4'hF, 32'h0000_0006, 32'h0, 0};
        ops[17] = '{P_LVL,  0, 32'h4,         4'h0, 32'h0,         32'h0, 0};
        ops[18] = '{P_DATA, 0, 32'h0000_2000, 4'hF, 32'h0,         32'h0, 0};
        ops[19] = '{P_APB,  1, 32'h0,         4'h0, 32'h0,         32'h0, 0};
        ops[20] = '{P_CODE, 0, 32'h0000_1000, 4'hF, 32'h0,         32'h0, 0};
        ops[21] = '{P_BOTH, 0, 32'h0,         4'h0, 32'h0,         32'h0, 0};
        ops[22] = '{P_APB,  0, 32'h4,         4'h0, 32'h0,         32'h0, 0};
        repeat (4) @(negedge i_clk);
        i_arst_n = 1'b1;
        for (int i = 0; i < NUM_OPS; i++) begin
                if (ops[i].port == P_APB || ops[i].port == P_LVL) begin
                        apb_access(ops[i], rd, err);
                        check_bit("o_pslverr", err, ops[i].err);
                        if (ops[i].port == P_LVL && rd > 32'd4)
                                stop_run("Store buffer level read over APB is above four.");
                        else if (ops[i].port == P_APB && !ops[i].we)
                                check_word("o_prdata", rd, ops[i].exp);
                        if (ops[i].we && !ops[i].err && ops[i].adr[3:0] == 4'h0)
                                tb_pid = ops[i].dat[6:0];
                end else if (ops[i].port == P_BOTH) begin
                        both_ports();
                end else begin
                        ea = reloc(ops[i].port == P_CODE ? ops[i].adr & ~32'h3 : ops[i].adr);
                        ed = ops[i].dat;
                        if (ops[i].we)
                                ref_mem[ea >> 2] = merge(ref_read(ea), ed, ops[i].sel);
                        else
                                ed = ref_read(ea);
                        exp_adr.push_back(ea);
                        exp_we.push_back(ops[i].we);
                        exp_dat.push_back(ops[i].dat);
                        port_access(ops[i], rd);
                        if (!ops[i].we)
                                check_word(ops[i].port == P_CODE ? "o_ic_dat" : "o_dc_dat",
                                        rd, ed);
                end
        end
        if (exp_adr.size() != 0)
                stop_run("Some expected external transactions never appeared.");
        if (fails == 0) begin
                $display("Simulation PASSED");
                $finish;
        end else begin
                $display("Simulation FAILED");
                $fatal(1);
        end
end

endmodule

// ==== verif/zap_assertions.sv ====
// Bound protocol checks on the external Wishbone bus and the port acks.
module zap_assertions (
        input  logic                            i_clk,
        input  logic                            i_arst_n,
        input  logic                            o_wb_cyc,
        input  logic                            o_wb_stb,
        input  logic                            o_wb_we,
        input  logic [zap_pkg::ZAP_SELW-1:0]    o_wb_sel,
        input  logic [zap_pkg::ZAP_DW-1:0]      o_wb_dat,
        input  logic [zap_pkg::ZAP_AW-1:0]      o_wb_adr,
        input  logic                            i_wb_ack,
        input  logic                            o_ic_ack,
        input  logic                            o_dc_ack
);
timeunit 1ns;
timeprecision 1ps;

// ----------------------------------------------------------
// External bus.
// ----------------------------------------------------------

stb_needs_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb_stb |-> o_wb_cyc)
        else $error("external stb raised without cyc");

// Fields held while the slave stalls.
fields_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_we)
                && $stable(o_wb_sel) && $stable(o_wb_dat)))
        else $error("external request changed before ack");

// One owner at a time.
acks_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_ic_ack && o_dc_ack))
        else $error("code and data acks high together");

endmodule

bind zap_top zap_assertions u_zap_assertions (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .o_wb_cyc (o_wb_cyc), .o_wb_stb (o_wb_stb), .o_wb_we (o_wb_we),
        .o_wb_sel (o_wb_sel), .o_wb_dat (o_wb_dat), .o_wb_adr (o_wb_adr),
        .i_wb_ack (i_wb_ack), .o_ic_ack (o_ic_ack), .o_dc_ack (o_dc_ack)
);

// ==== verilog/zap_top.sv ====
// Subsystem top level wiring the config registers, bus merger and bus adapter.
module zap_top (
        // Clock and reset.
        input  logic                            i_clk,
        input  logic                            i_arst_n,

        // Code port, read only.
        input  logic                            i_ic_stb,
        input  logic [zap_pkg::ZAP_AW-1:0]      i_ic_adr,
        output logic                            o_ic_ack,
        output logic [zap_pkg::ZAP_DW-1:0]      o_ic_dat,

        // Data port.
        input  logic                            i_dc_stb,
        input  logic                            i_dc_we,
        input  logic [zap_pkg::ZAP_SELW-1:0]    i_dc_sel,
        input  logic [zap_pkg::ZAP_AW-1:0]      i_dc_adr,
        input  logic [zap_pkg::ZAP_DW-1:0]      i_dc_dat,
        output logic                            o_dc_ack,
        output logic [zap_pkg::ZAP_DW-1:0]      o_dc_dat,

        // APB slave.
        input  logic                            i_psel,
        input  logic                            i_penable,
        input  logic                            i_pwrite,
        input  logic [zap_pkg::ZAP_APB_AW-1:0]  i_paddr,
        input  logic [zap_pkg::ZAP_DW-1:0]      i_pwdata,
        output logic [zap_pkg::ZAP_DW-1:0]      o_prdata,
        output logic                            o_pready,
        output logic                            o_pslverr,

        // External Wishbone master.
        output logic                            o_wb_cyc,
        output logic                            o_wb_stb,
        output logic                            o_wb_we,
        output logic [zap_pkg::ZAP_SELW-1:0]    o_wb_sel,
        output logic [zap_pkg::ZAP_DW-1:0]      o_wb_dat,
        output logic [zap_pkg::ZAP_AW-1:0]      o_wb_adr,
        input  logic                            i_wb_ack,
        input  logic [zap_pkg::ZAP_DW-1:0]      i_wb_dat
);

logic [zap_pkg::ZAP_PID_W-1:0]  pid;            // Process ID to merger.
logic [zap_pkg::ZAP_SB_LVL_W-1:0] sb_level;     // Buffer fill to status reg.

// Internal Wishbone path, merger to adapter.
logic                           m_cyc, m_stb, m_we, m_ack;
logic [zap_pkg::ZAP_SELW-1:0]   m_sel;
logic [zap_pkg::ZAP_DW-1:0]     m_dat, m_rdat;
logic [zap_pkg::ZAP_AW-1:0]     m_adr;

zap_cfg_regs u_zap_cfg_regs (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
        .i_paddr (i_paddr), .i_pwdata (i_pwdata), .o_prdata (o_prdata),
        .o_pready (o_pready), .o_pslverr (o_pslverr),
        .i_sb_level (sb_level), .o_pid (pid)
);

zap_wb_merger u_zap_wb_merger (
        .i_clk (i_clk), .i_arst_n (i_arst_n), .i_pid (pid),
        .i_ic_stb (i_ic_stb), .i_ic_adr (i_ic_adr),
        .o_ic_ack (o_ic_ack), .o_ic_dat (o_ic_dat),
        .i_dc_stb (i_dc_stb), .i_dc_we (i_dc_we), .i_dc_sel (i_dc_sel),
        .i_dc_adr (i_dc_adr), .i_dc_dat (i_dc_dat),
        .o_dc_ack (o_dc_ack), .o_dc_dat (o_dc_dat),
        .o_m_cyc (m_cyc), .o_m_stb (m_stb), .o_m_we (m_we), .o_m_sel (m_sel),
        .o_m_dat (m_dat), .o_m_adr (m_adr), .i_m_ack (m_ack), .i_m_rdat (m_rdat)
);

zap_wb_adapter u_zap_wb_adapter (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .i_m_cyc (m_cyc), .i_m_stb (m_stb), .i_m_we (m_we), .i_m_sel (m_sel),
        .i_m_dat (m_dat), .i_m_adr (m_adr), .o_m_ack (m_ack), .o_m_rdat (m_rdat),
        .o_wb_cyc (o_wb_cyc), .o_wb_stb (o_wb_stb), .o_wb_we (o_wb_we),
        .o_wb_sel (o_wb_sel), .o_wb_dat (o_wb_dat), .o_wb_adr (o_wb_adr),
        .i_wb_ack (i_wb_ack), .i_wb_dat (i_wb_dat),
        .o_sb_level (sb_level)
);

endmodule

// ==== wb_adapter/zap_wb_adapter.sv ====
// Wishbone adapter with posted writes, ordered reads and external bus FSM.
module zap_wb_adapter (
        input  logic                                    i_clk,
        input  logic                                    i_arst_n,

        // Internal Wishbone path.
        input  logic                                    i_m_cyc,
        input  logic                                    i_m_stb,
        input  logic                                    i_m_we,
        input  logic [zap_pkg::ZAP_SELW-1:0]            i_m_sel,
        input  logic [zap_pkg::ZAP_DW-1:0]              i_m_dat,
        input  logic [zap_pkg::ZAP_AW-1:0]              i_m_adr,
        output logic                                    o_m_ack,
        output logic [zap_pkg::ZAP_DW-1:0]              o_m_rdat,

        // External Wishbone master.
        output logic                                    o_wb_cyc,
        output logic                                    o_wb_stb,
        output logic                                    o_wb_we,
        output logic [zap_pkg::ZAP_SELW-1:0]            o_wb_sel,
        output logic [zap_pkg::ZAP_DW-1:0]              o_wb_dat,
        output logic [zap_pkg::ZAP_AW-1:0]              o_wb_adr,
        input  logic                                    i_wb_ack,
        input  logic [zap_pkg::ZAP_DW-1:0]              i_wb_dat,

        output logic [zap_pkg::ZAP_SB_LVL_W-1:0]        o_sb_level
);

typedef enum logic [1:0] {S_IDLE, S_WRITE, S_READ} state_t;

state_t                         state;
logic                           wr_req, rd_req;
logic                           sb_push, sb_pop, sb_empty, sb_full;
logic [zap_pkg::ZAP_AW-1:0]     sb_adr;
logic [zap_pkg::ZAP_SELW-1:0]   sb_sel;
logic [zap_pkg::ZAP_DW-1:0]     sb_dat;

// Ack blanks the request for its own cycle.
assign wr_req  = i_m_cyc & i_m_stb &  i_m_we & ~o_m_ack;
assign rd_req  = i_m_cyc & i_m_stb & ~i_m_we & ~o_m_ack;
assign sb_push = wr_req & ~sb_full;             // Full withholds the ack.
assign sb_pop  = (state == S_WRITE) & i_wb_ack; // Head retired.
assign o_wb_cyc = o_wb_stb;

zap_store_buffer #(.DEPTH(zap_pkg::ZAP_SB_DEPTH)) u_zap_store_buffer (
        .i_clk (i_clk), .i_arst_n (i_arst_n),
        .i_push (sb_push), .i_adr (i_m_adr), .i_sel (i_m_sel), .i_dat (i_m_dat),
        .i_pop (sb_pop), .o_adr (sb_adr), .o_sel (sb_sel), .o_dat (sb_dat),
        .o_empty (sb_empty), .o_full (sb_full), .o_level (o_sb_level)
);

// ----------------------------------------------------------
// External bus FSM. Drain first, then reads.
// ----------------------------------------------------------

always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
                state    <= S_IDLE;
                o_wb_stb <= 1'b0;
                o_m_ack  <= 1'b0;
        end else begin
                // Early write ack, or read ack a cycle after the slave.
                o_m_ack <= sb_push | ((state == S_READ) & i_wb_ack);
                case (state)
                S_IDLE: begin
                        if (!sb_empty) begin
                                state    <= S_WRITE;
                                o_wb_stb <= 1'b1;
                        end else if (rd_req) begin
                                state    <= S_READ;   // Buffer empty, order kept.
                                o_wb_stb <= 1'b1;
                        end
                end
                S_WRITE, S_READ: begin
                        if (i_wb_ack) begin
                                state    <= S_IDLE;   // One transaction at a time.
                                o_wb_stb <= 1'b0;
                        end
                end
                default: state <= S_IDLE;
                endcase
        end
end

// External fields load as a transaction starts.
always_ff @(posedge i_clk) begin
        if (state == S_IDLE && !sb_empty) begin
                o_wb_we  <= 1'b1;
                o_wb_sel <= sb_sel;
                o_wb_dat <= sb_dat;
                o_wb_adr <= sb_adr;
        end else if (state == S_IDLE) begin
                o_wb_we  <= 1'b0;
                o_wb_sel <= i_m_sel;
                o_wb_dat <= i_m_dat;
                o_wb_adr <= i_m_adr;
        end
        if (state == S_READ && i_wb_ack)
                o_m_rdat <= i_wb_dat;           // Captured read data.
end

endmodule

// ==== wb_adapter/zap_store_buffer.sv ====
// Circular FIFO of posted writes holding address, byte select and data.
module zap_store_buffer #(
        parameter int unsigned DEPTH = zap_pkg::ZAP_SB_DEPTH
) (
        input  logic                                    i_clk,
        input  logic                                    i_arst_n,
        input  logic                                    i_push,
        input  logic [zap_pkg::ZAP_AW-1:0]              i_adr,
        input  logic [zap_pkg::ZAP_SELW-1:0]            i_sel,
        input  logic [zap_pkg::ZAP_DW-1:0]              i_dat,
        input  logic                                    i_pop,
        output logic [zap_pkg::ZAP_AW-1:0]              o_adr,
        output logic [zap_pkg::ZAP_SELW-1:0]            o_sel,
        output logic [zap_pkg::ZAP_DW-1:0]              o_dat,
        output logic                                    o_empty,
        output logic                                    o_full,
        output logic [zap_pkg::ZAP_SB_LVL_W-1:0]        o_level
);

localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer bits.
localparam int unsigned CW = $clog2(DEPTH + 1);                // Count bits.

logic [zap_pkg::ZAP_AW-1:0]     mem_adr [DEPTH];
logic [zap_pkg::ZAP_SELW-1:0]   mem_sel [DEPTH];
logic [zap_pkg::ZAP_DW-1:0]     mem_dat [DEPTH];
logic [PW-1:0]                  wr_ptr, rd_ptr;
logic [CW-1:0]                  count;
logic                           push_ok, pop_ok;

assign o_empty = (count == '0);
assign o_full  = (count == CW'(DEPTH));
assign push_ok = i_push & ~o_full;              // Overflow dropped.
assign pop_ok  = i_pop & ~o_empty;              // Underflow dropped.
assign o_level = zap_pkg::ZAP_SB_LVL_W'(count);
assign o_adr   = mem_adr[rd_ptr];               // Head of queue.
assign o_sel   = mem_sel[rd_ptr];
assign o_dat   = mem_dat[rd_ptr];

always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
        end else begin
                if (push_ok)
                        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                if (pop_ok)
                        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                count <= count + CW'(push_ok) - CW'(pop_ok);  // Both may happen.
        end
end

always_ff @(posedge i_clk) begin
        if (push_ok) begin
                mem_adr[wr_ptr] <= i_adr;
                mem_sel[wr_ptr] <= i_sel;
                mem_dat[wr_ptr] <= i_dat;
        end
end

endmodule

// ==== verilog/zap_wb_merger.sv ====
// Code/data port arbiter with FCSE relocation onto one internal Wishbone path.
module zap_wb_merger (
        input  logic                            i_clk,
        input  logic                            i_arst_n,
        input  logic [zap_pkg::ZAP_PID_W-1:0]   i_pid,

        // Code port.
        input  logic                            i_ic_stb,
        input  logic [zap_pkg::ZAP_AW-1:0]      i_ic_adr,
        output logic                            o_ic_ack,
        output logic [zap_pkg::ZAP_DW-1:0]      o_ic_dat,

        // Data port.
        input  logic                            i_dc_stb,
        input  logic                            i_dc_we,
        input  logic [zap_pkg::ZAP_SELW-1:0]    i_dc_sel,
        input  logic [zap_pkg::ZAP_AW-1:0]      i_dc_adr,
        input  logic [zap_pkg::ZAP_DW-1:0]      i_dc_dat,
        output logic                            o_dc_ack,
        output logic [zap_pkg::ZAP_DW-1:0]      o_dc_dat,

        // Internal Wishbone path.
        output logic                            o_m_cyc,
        output logic                            o_m_stb,
        output logic                            o_m_we,
        output logic [zap_pkg::ZAP_SELW-1:0]    o_m_sel,
        output logic [zap_pkg::ZAP_DW-1:0]      o_m_dat,
        output logic [zap_pkg::ZAP_AW-1:0]      o_m_adr,
        input  logic                            i_m_ack,
        input  logic [zap_pkg::ZAP_DW-1:0]      i_m_rdat
);

logic own_d;            // Current owner is the data port.
logic last_d;           // Data port served last.
logic gnt_c, gnt_d;

// Relocate into the PID slot when the address sits in the low 32 MB.
function automatic logic [zap_pkg::ZAP_AW-1:0] fcse(
        input logic [zap_pkg::ZAP_AW-1:0]    adr,
        input logic [zap_pkg::ZAP_PID_W-1:0] pid
);
        logic [zap_pkg::ZAP_AW-1:0] offs;
        offs = pid;
        offs = offs << zap_pkg::ZAP_FCSE_SHIFT;
        if (adr[zap_pkg::ZAP_AW-1 -: zap_pkg::ZAP_FCSE_LIMIT_W] == '0)
                return adr + offs;
        return adr;                             // Upper space is global.
endfunction

// Fair pick. A lone requester wins at once.
assign gnt_d = i_dc_stb & (~i_ic_stb | ~last_d);
assign gnt_c = i_ic_stb & ~gnt_d;

assign o_m_cyc  = o_m_stb;
assign o_ic_ack = i_m_ack & o_m_stb & ~own_d;   // Ack to owner, same cycle.
assign o_dc_ack = i_m_ack & o_m_stb &  own_d;
assign o_ic_dat = i_m_rdat;
assign o_dc_dat = i_m_rdat;

always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
                o_m_stb <= 1'b0;
                own_d   <= 1'b0;
                last_d  <= 1'b0;
        end else if (!o_m_stb) begin
                if (gnt_c || gnt_d) begin       // Grant only when idle.
                        o_m_stb <= 1'b1;
                        own_d   <= gnt_d;
                        last_d  <= gnt_d;
                end
        end else if (i_m_ack) begin
                o_m_stb <= 1'b0;                // Done. Rearbitrate next cycle.
        end
end

// Winning request fields.
always_ff @(posedge i_clk) begin
        if (!o_m_stb && gnt_d) begin
                o_m_we  <= i_dc_we;
                o_m_sel <= i_dc_sel;
                o_m_dat <= i_dc_dat;
                o_m_adr <= fcse(i_dc_adr, i_pid);
        end else if (!o_m_stb && gnt_c) begin
                o_m_we  <= 1'b0;                // Full word read.
                o_m_sel <= '1;
                o_m_dat <= '0;
                o_m_adr <= fcse({i_ic_adr[zap_pkg::ZAP_AW-1:2], 2'b00}, i_pid);
        end
end

endmodule

// ==== verilog/zap_cfg_regs.sv ====
// APB slave holding the FCSE process ID and reporting the store buffer level.
module zap_cfg_regs (
        input  logic                                    i_clk,
        input  logic                                    i_arst_n,

        // APB slave.
        input  logic                                    i_psel,
        input  logic                                    i_penable,
        input  logic                                    i_pwrite,
        input  logic [zap_pkg::ZAP_APB_AW-1:0]          i_paddr,
        input  logic [zap_pkg::ZAP_DW-1:0]              i_pwdata,
        output logic [zap_pkg::ZAP_DW-1:0]              o_prdata,
        output logic                                    o_pready,
        output logic                                    o_pslverr,

        // Status in, PID out.
        input  logic [zap_pkg::ZAP_SB_LVL_W-1:0]        i_sb_level,
        output logic [zap_pkg::ZAP_PID_W-1:0]           o_pid
);

logic access;                   // APB access phase.
logic hit_pid, hit_stat;        // Address decode.
logic bad;                      // Unknown address or write to status.

assign access   = i_psel & i_penable;
assign hit_pid  = (i_paddr == zap_pkg::ZAP_REG_PID);
assign hit_stat = (i_paddr == zap_pkg::ZAP_REG_STAT);
assign bad      = ~hit_pid & ~(hit_stat & ~i_pwrite);

assign o_pready  = 1'b1;                // Zero wait states.
assign o_pslverr = access & bad;        // Flagged in access phase only.

// Read mux. Bad accesses read zero.
always_comb begin
        o_prdata = '0;
        if (!i_pwrite && hit_pid) begin
                o_prdata[zap_pkg::ZAP_PID_W-1:0] = o_pid;
        end else if (!i_pwrite && hit_stat) begin
                o_prdata[zap_pkg::ZAP_SB_LVL_W-1:0] = i_sb_level;  // Live level.
        end
end

// ----------------------------------------------------------
// PID register.
// ----------------------------------------------------------

always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
                o_pid <= '0;                    // No relocation after reset.
        end else if (access && i_pwrite && hit_pid) begin
                o_pid <= i_pwdata[zap_pkg::ZAP_PID_W-1:0];
        end
end

endmodule

// ==== common/zap_pkg.sv ====
// Bus widths, FCSE constants, APB register map and store buffer sizing.
package zap_pkg;

// ----------------------------------------------------------
// Bus widths.
// ----------------------------------------------------------

localparam int unsigned ZAP_AW   = 32;    // Address width.
localparam int unsigned ZAP_DW   = 32;    // Data width.
localparam int unsigned ZAP_SELW = 4;     // One select per byte.

// ----------------------------------------------------------
// Fast context switch extension.
// ----------------------------------------------------------

// Process ID width.
localparam int unsigned ZAP_PID_W        = 7;
localparam int unsigned ZAP_FCSE_SHIFT   = 25;    // PID lands on 32 MB boundaries.
localparam int unsigned ZAP_FCSE_LIMIT_W = 7;     // Top bits that must be zero.

// ----------------------------------------------------------
// Store buffer.
// ----------------------------------------------------------

localparam int unsigned ZAP_SB_DEPTH = 4;         // Posted writes held.
localparam int unsigned ZAP_SB_LVL_W = 3;         // Holds 0 to DEPTH.

// ----------------------------------------------------------
// APB register map.
// ----------------------------------------------------------

localparam int unsigned ZAP_APB_AW = 4;

// PID register, read/write.
localparam logic [ZAP_APB_AW-1:0] ZAP_REG_PID  = 4'h0;
// Store buffer level, read only.
localparam logic [ZAP_APB_AW-1:0] ZAP_REG_STAT = 4'h4;

endpackage
